//--- source/fetch_params.svh
// Size and reset macros for the fetch front end, included by the package and the RTL files
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Byte address width
`define FETCH_AW 32

// Instructions per fetch window, a power of two
`define FETCH_WIDTH 2

// Fetch queue entries, a power of two
`define FETCH_IQ_DEPTH 8

// log2 of the BTB entry count
`define FETCH_BTB_P_NUM 4

// First fetch address after reset, in bytes
`define FETCH_RST_VECTOR 32'h0000_1000

`endif

//--- source/fetch_pkg.sv
// Shared types of the fetch front end, imported by each RTL module that uses them
`include "fetch_params.svh"

package fetch_pkg;

   // Instruction address, byte offset bits dropped
   typedef logic [`FETCH_AW-3:0] pc_t;

   typedef logic [31:0] insn_t;

   // Direct-mapped BTB index, low bits of a pc_t
   typedef logic [`FETCH_BTB_P_NUM-1:0] btb_idx_t;

   // Four-phase memory port states
   typedef enum logic [1:0] {
      IMEM_IDLE,
      IMEM_WAIT_ACK,
      IMEM_WAIT_RELEASE
   } imem_state_t;

endpackage

//--- source/pc_gen.sv
// Program counter and next-PC logic, instantiated by the fetch front end top level
`include "fetch_params.svh"

module pc_gen
   import fetch_pkg::*;
(
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic                               flush,
   input  pc_t                                flush_tgt,
   input  logic                               fetch_done,
   input  logic                               port_idle,
   input  logic                               iq_ready,
   input  logic [`FETCH_WIDTH-1:0]            slot_hit,
   input  pc_t  [`FETCH_WIDTH-1:0]            slot_tgt,
   output logic                               fetch_start,
   output pc_t                                fetch_pc,
   output logic [$clog2(`FETCH_WIDTH):0]      push_cnt,
   output logic [`FETCH_WIDTH-1:0]            slot_valid
);
   localparam int P_FW = $clog2(`FETCH_WIDTH);

   pc_t              pc;
   pc_t              pc_nxt;
   pc_t              pred_tgt;
   logic             pred_taken;
   logic             blocked;
   logic [P_FW-1:0]  slot_ofs;

   // Window base and the slot the PC points at
   assign fetch_pc = pc & ~pc_t'(`FETCH_WIDTH - 1);
   assign slot_ofs = pc[P_FW-1:0];

   // Slot mask at or after the PC and cut after the first predicted-taken slot
   always_comb
   begin
      blocked = 1'b0;
      pred_taken = 1'b0;
      pred_tgt = pc;
      push_cnt = '0;
      for (int i = 0; i < `FETCH_WIDTH; i++)
      begin
         slot_valid[i] = (int'(slot_ofs) <= i) && !blocked;
         if (slot_valid[i])
         begin
            push_cnt++;
            if (slot_hit[i])
            begin
               pred_taken = 1'b1;
               pred_tgt = slot_tgt[i];
               blocked = 1'b1;
            end
         end
      end
   end

   assign pc_nxt = pred_taken ? pred_tgt : pc + pc_t'(push_cnt);

   // Flush wins over the window result
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         pc <= pc_t'(`FETCH_RST_VECTOR >> 2);
      else if (flush)
         pc <= flush_tgt;
      else if (fetch_done)
         pc <= pc_nxt;
   end

   // One-cycle request while the port sits idle and two queue slots are free
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         fetch_start <= 1'b0;
      else
         fetch_start <= port_idle && iq_ready && !fetch_start && !flush;
   end

   a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(fetch_start) |-> port_idle);

endmodule

//--- source/btb.sv
// Direct-mapped branch target buffer, looked up per fetch slot and written from execute
`include "fetch_params.svh"

module btb
   import fetch_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  pc_t                      fetch_pc,
   input  logic                     bpu_wb,
   input  logic                     bpu_wb_taken,
   input  pc_t                      bpu_wb_pc,
   input  pc_t                      bpu_wb_tgt,
   output logic [`FETCH_WIDTH-1:0]  slot_hit,
   output pc_t  [`FETCH_WIDTH-1:0]  slot_tgt
);
   localparam int BTB_NUM = 1 << `FETCH_BTB_P_NUM;
   localparam int TAG_W   = `FETCH_AW - 2 - `FETCH_BTB_P_NUM;

   logic [BTB_NUM-1:0]  ent_valid;
   logic [TAG_W-1:0]    ent_tag [BTB_NUM];
   pc_t                 ent_tgt [BTB_NUM];

   btb_idx_t            wb_idx;
   logic [TAG_W-1:0]    wb_tag;

   assign wb_idx = bpu_wb_pc[`FETCH_BTB_P_NUM-1:0];
   assign wb_tag = bpu_wb_pc[`FETCH_AW-3:`FETCH_BTB_P_NUM];

   // Read port per slot of the window
   for (genvar i = 0; i < `FETCH_WIDTH; i++)
   begin : g_slot
      pc_t        slot_pc;
      btb_idx_t   rd_idx;

      assign slot_pc = fetch_pc + pc_t'(i);
      assign rd_idx = slot_pc[`FETCH_BTB_P_NUM-1:0];
      assign slot_hit[i] = ent_valid[rd_idx] &&
                           (ent_tag[rd_idx] == slot_pc[`FETCH_AW-3:`FETCH_BTB_P_NUM]);
      assign slot_tgt[i] = ent_tgt[rd_idx];
   end

   // Taken sets the entry; not-taken drops it only on a tag match
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         ent_valid <= '0;
      else if (bpu_wb)
      begin
         if (bpu_wb_taken)
            ent_valid[wb_idx] <= 1'b1;
         else if (ent_tag[wb_idx] == wb_tag)
            ent_valid[wb_idx] <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (bpu_wb && bpu_wb_taken)
      begin
         ent_tag[wb_idx] <= wb_tag;
         ent_tgt[wb_idx] <= bpu_wb_tgt;
      end
   end

endmodule

//--- source/imem_port.sv
// Four-phase req/ack master that reads one fetch window from instruction memory
`include "fetch_params.svh"

module imem_port
   import fetch_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     fetch_start,
   input  pc_t                      fetch_pc,
   input  logic                     flush,
   input  logic                     imem_ack,
   input  insn_t [`FETCH_WIDTH-1:0] imem_rdata,
   output logic                     imem_req,
   output pc_t                      imem_addr,
   output logic                     port_idle,
   output logic                     fetch_done,
   output insn_t [`FETCH_WIDTH-1:0] fetch_ins
);
   imem_state_t   state;
   // Window went stale through a flush
   logic          killed;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state <= IMEM_IDLE;
         imem_req <= 1'b0;
         killed <= 1'b0;
         fetch_done <= 1'b0;
      end
      else
      begin
         fetch_done <= 1'b0;
         case (state)
            IMEM_IDLE:
               if (fetch_start)
               begin
                  state <= IMEM_WAIT_ACK;
                  imem_req <= 1'b1;
                  killed <= flush;
               end
            IMEM_WAIT_ACK:
               if (imem_ack)
               begin
                  state <= IMEM_WAIT_RELEASE;
                  imem_req <= 1'b0;
                  fetch_done <= !(killed || flush);
               end
               else
                  killed <= killed || flush;
            // Memory has to drop ack before the next request
            IMEM_WAIT_RELEASE:
               if (!imem_ack)
                  state <= IMEM_IDLE;
            default:
               state <= IMEM_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == IMEM_IDLE && fetch_start)
         imem_addr <= fetch_pc;
      if (state == IMEM_WAIT_ACK && imem_ack)
         fetch_ins <= imem_rdata;
   end

   assign port_idle = (state == IMEM_IDLE);

   a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      imem_req && !imem_ack |=> imem_req);
   a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
      imem_req |=> !imem_req || $stable(imem_addr));

endmodule

//--- source/fetch_queue.sv
// Fetch queue between the fetch window and decode, pushed and popped up to two wide
`include "fetch_params.svh"

module fetch_queue
   import fetch_pkg::*;
(
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              flush,
   input  logic [$clog2(`FETCH_WIDTH):0]     push_cnt,
   input  logic                              fetch_done,
   input  insn_t [`FETCH_WIDTH-1:0]          fetch_ins,
   input  pc_t                               fetch_pc,
   input  logic [`FETCH_WIDTH-1:0]           slot_valid,
   input  logic [`FETCH_WIDTH-1:0]           slot_hit,
   input  pc_t   [`FETCH_WIDTH-1:0]          slot_tgt,
   input  logic [$clog2(`FETCH_WIDTH):0]     id_pop_cnt,
   output logic                              iq_ready,
   output logic [`FETCH_WIDTH-1:0]           id_valid,
   output insn_t [`FETCH_WIDTH-1:0]          id_ins,
   output pc_t   [`FETCH_WIDTH-1:0]          id_pc,
   output logic [`FETCH_WIDTH-1:0]           id_pred_taken,
   output pc_t   [`FETCH_WIDTH-1:0]          id_pred_tgt
);
   localparam int P_DEPTH = $clog2(`FETCH_IQ_DEPTH);

   typedef logic [P_DEPTH-1:0] ptr_t;
   typedef logic [P_DEPTH:0]   cnt_t;

   ptr_t    rptr;
   ptr_t    wptr;
   cnt_t    count;
   cnt_t    push_n;
   ptr_t    wr_ptr [`FETCH_WIDTH];

   insn_t   q_ins   [`FETCH_IQ_DEPTH];
   pc_t     q_pc    [`FETCH_IQ_DEPTH];
   logic    q_taken [`FETCH_IQ_DEPTH];
   pc_t     q_tgt   [`FETCH_IQ_DEPTH];

   assign push_n = fetch_done ? cnt_t'(push_cnt) : '0;

   // Compact the valid slots onto consecutive entries
   always_comb
   begin
      wr_ptr[0] = wptr;
      for (int i = 1; i < `FETCH_WIDTH; i++)
         wr_ptr[i] = wr_ptr[i-1] + ptr_t'(slot_valid[i-1]);
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n || flush)
      begin
         rptr <= '0;
         wptr <= '0;
         count <= '0;
      end
      else
      begin
         rptr <= rptr + ptr_t'(id_pop_cnt);
         wptr <= wptr + ptr_t'(push_n);
         count <= count + push_n - cnt_t'(id_pop_cnt);
      end
   end

   always_ff @(posedge clk)
   begin
      if (fetch_done && !flush)
         for (int i = 0; i < `FETCH_WIDTH; i++)
            if (slot_valid[i])
            begin
               q_ins[wr_ptr[i]] <= fetch_ins[i];
               q_pc[wr_ptr[i]] <= fetch_pc + pc_t'(i);
               q_taken[wr_ptr[i]] <= slot_hit[i];
               q_tgt[wr_ptr[i]] <= slot_tgt[i];
            end
   end

   // Head entries towards decode
   for (genvar i = 0; i < `FETCH_WIDTH; i++)
   begin : g_issue
      ptr_t rd_ptr;

      assign rd_ptr = rptr + ptr_t'(i);
      assign id_valid[i] = (count > cnt_t'(i));
      assign id_ins[i] = q_ins[rd_ptr];
      assign id_pc[i] = q_pc[rd_ptr];
      assign id_pred_taken[i] = q_taken[rd_ptr];
      assign id_pred_tgt[i] = q_tgt[rd_ptr];
   end

   // Room for a full window
   assign iq_ready = (count <= cnt_t'(`FETCH_IQ_DEPTH - `FETCH_WIDTH));

   a_pop_bound: assert property (@(posedge clk) disable iff (!rst_n)
      int'(id_pop_cnt) <= $countones(id_valid));

endmodule

//--- source/fetch_frontend.sv
// Top level of the instruction fetch front end, connecting PC, BTB, memory port and queue
`include "fetch_params.svh"

module fetch_frontend
   import fetch_pkg::*;
(
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              flush,
   input  pc_t                               flush_tgt,
   // From execute
   input  logic                              bpu_wb,
   input  logic                              bpu_wb_taken,
   input  pc_t                               bpu_wb_pc,
   input  pc_t                               bpu_wb_tgt,
   // Instruction memory
   output logic                              imem_req,
   output pc_t                               imem_addr,
   input  logic                              imem_ack,
   input  insn_t [`FETCH_WIDTH-1:0]          imem_rdata,
   // To decode
   output logic [`FETCH_WIDTH-1:0]           id_valid,
   output insn_t [`FETCH_WIDTH-1:0]          id_ins,
   output pc_t   [`FETCH_WIDTH-1:0]          id_pc,
   output logic [`FETCH_WIDTH-1:0]           id_pred_taken,
   output pc_t   [`FETCH_WIDTH-1:0]          id_pred_tgt,
   input  logic [$clog2(`FETCH_WIDTH):0]     id_pop_cnt
);
   logic                            fetch_start;
   logic                            fetch_done;
   logic                            port_idle;
   logic                            iq_ready;
   pc_t                             fetch_pc;
   logic [$clog2(`FETCH_WIDTH):0]   push_cnt;
   logic [`FETCH_WIDTH-1:0]         slot_valid;
   logic [`FETCH_WIDTH-1:0]         slot_hit;
   pc_t   [`FETCH_WIDTH-1:0]        slot_tgt;
   insn_t [`FETCH_WIDTH-1:0]        fetch_ins;

   pc_gen pc_gen_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .flush         (flush),
      .flush_tgt     (flush_tgt),
      .fetch_done    (fetch_done),
      .port_idle     (port_idle),
      .iq_ready      (iq_ready),
      .slot_hit      (slot_hit),
      .slot_tgt      (slot_tgt),
      .fetch_start   (fetch_start),
      .fetch_pc      (fetch_pc),
      .push_cnt      (push_cnt),
      .slot_valid    (slot_valid)
   );

   btb btb_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .fetch_pc      (fetch_pc),
      .bpu_wb        (bpu_wb),
      .bpu_wb_taken  (bpu_wb_taken),
      .bpu_wb_pc     (bpu_wb_pc),
      .bpu_wb_tgt    (bpu_wb_tgt),
      .slot_hit      (slot_hit),
      .slot_tgt      (slot_tgt)
   );

   imem_port imem_port_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .fetch_start   (fetch_start),
      .fetch_pc      (fetch_pc),
      .flush         (flush),
      .imem_ack      (imem_ack),
      .imem_rdata    (imem_rdata),
      .imem_req      (imem_req),
      .imem_addr     (imem_addr),
      .port_idle     (port_idle),
      .fetch_done    (fetch_done),
      .fetch_ins     (fetch_ins)
   );

   fetch_queue fetch_queue_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .flush         (flush),
      .push_cnt      (push_cnt),
      .fetch_done    (fetch_done),
      .fetch_ins     (fetch_ins),
      .fetch_pc      (fetch_pc),
      .slot_valid    (slot_valid),
      .slot_hit      (slot_hit),
      .slot_tgt      (slot_tgt),
      .id_pop_cnt    (id_pop_cnt),
      .iq_ready      (iq_ready),
      .id_valid      (id_valid),
      .id_ins        (id_ins),
      .id_pc         (id_pc),
      .id_pred_taken (id_pred_taken),
      .id_pred_tgt   (id_pred_tgt)
   );

endmodule

//--- verification/fetch_checker.sv
// Decode-side monitor for the fetch front end, compares issued instructions with a reference model
`include "fetch_params.svh"

module fetch_checker
   import fetch_pkg::*;
(
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              flush,
   input  pc_t                               flush_tgt,
   input  logic                              bpu_wb,
   input  logic                              bpu_wb_taken,
   input  pc_t                               bpu_wb_pc,
   input  pc_t                               bpu_wb_tgt,
   input  logic [`FETCH_WIDTH-1:0]           id_valid,
   input  insn_t [`FETCH_WIDTH-1:0]          id_ins,
   input  pc_t   [`FETCH_WIDTH-1:0]          id_pc,
   input  logic [`FETCH_WIDTH-1:0]           id_pred_taken,
   input  pc_t   [`FETCH_WIDTH-1:0]          id_pred_tgt,
   input  logic [$clog2(`FETCH_WIDTH):0]     id_pop_cnt,
   input  logic                              run_done,
   output int                                err_cnt,
   output logic                              report_done
);
   localparam int MIN_ISSUED = 500;
   // Byte address 32'h1000 in instruction units
   localparam pc_t RESET_PC = pc_t'('h400);

   typedef logic [2*$bits(pc_t)-1:0] pair_t;

   // Taken targets ever written per PC
   bit      taken_seen [pair_t];
   pc_t     exp_pc;
   logic    flush_seen;
   int      issued;

   // Memory contents as the responder serves them
   function automatic insn_t expected_word(pc_t p);
      return insn_t'({2'b00, p}) ^ 32'h5a5a_0000;
   endfunction

   task automatic report_mismatch(input string msg);
      $display("[FAIL] %0t: %s", $time, msg);
      err_cnt++;
   endtask

   always @(posedge clk)
   begin
      pc_t                       pc;
      logic [`FETCH_WIDTH-1:0]   lower;
      if (!rst_n)
      begin
         exp_pc = RESET_PC;
         flush_seen = 1'b0;
         issued = 0;
         err_cnt = 0;
         report_done = 1'b0;
      end
      else if (!report_done)
      begin
         if (bpu_wb && bpu_wb_taken)
            taken_seen[{bpu_wb_pc, bpu_wb_tgt}] = 1'b1;
         if (flush_seen && id_valid != '0)
            report_mismatch($sformatf("id_valid %b one cycle after flush", id_valid));
         // A slot may only be valid when all lower slots are
         lower = {id_valid[`FETCH_WIDTH-2:0], 1'b1};
         if ((id_valid & ~lower) != '0)
            report_mismatch($sformatf("id_valid %b is not a thermometer code", id_valid));
         for (int i = 0; i < int'(id_pop_cnt); i++)
         begin
            pc = id_pc[i];
            if (!id_valid[i])
               report_mismatch($sformatf("slot %0d popped while not valid", i));
            if (pc != exp_pc)
               report_mismatch($sformatf("slot %0d PC %h, expected %h", i, pc, exp_pc));
            if (id_ins[i] != expected_word(pc))
               report_mismatch($sformatf("PC %h word %h, expected %h",
                                         pc, id_ins[i], expected_word(pc)));
            if (id_pred_taken[i] && !taken_seen.exists({pc, id_pred_tgt[i]}))
               report_mismatch($sformatf("PC %h predicted taken to %h, never written",
                                         pc, id_pred_tgt[i]));
            // Next PC follows the prediction of this instruction
            exp_pc = id_pred_taken[i] ? id_pred_tgt[i] : pc + pc_t'(1);
            issued++;
         end
         if (flush)
            exp_pc = flush_tgt;
         flush_seen = flush;
         if (run_done)
         begin
            if (issued < MIN_ISSUED)
            begin
               $display("Too few instructions issued: %0d, at least %0d needed",
                        issued, MIN_ISSUED);
               err_cnt++;
            end
            $display("Checker done: %0d instructions issued, %0d errors", issued, err_cnt);
            report_done = 1'b1;
         end
      end
   end

endmodule

//--- verification/tb_fetch.sv
// Testbench top for the fetch front end with clock, reset, memory responder and random stimulus
`include "fetch_params.svh"

module tb_fetch
   import fetch_pkg::*;
();
   localparam int STIM_CYCLES = 4000;
   // Stimulus plus room for reset and drain
   localparam int TIMEOUT_CYCLES = STIM_CYCLES + STIM_CYCLES / 2;
   localparam int STALL_PHASE = 250;
   localparam int POP_W = $clog2(`FETCH_WIDTH) + 1;
   localparam pc_t REGION_BASE = pc_t'(`FETCH_RST_VECTOR >> 2);

   logic                            clk;
   logic                            rst_n;
   logic                            flush;
   pc_t                             flush_tgt;
   logic                            bpu_wb;
   logic                            bpu_wb_taken;
   pc_t                             bpu_wb_pc;
   pc_t                             bpu_wb_tgt;
   logic                            imem_req;
   pc_t                             imem_addr;
   logic                            imem_ack;
   insn_t [`FETCH_WIDTH-1:0]        imem_rdata;
   logic [`FETCH_WIDTH-1:0]         id_valid;
   insn_t [`FETCH_WIDTH-1:0]        id_ins;
   pc_t   [`FETCH_WIDTH-1:0]        id_pc;
   logic [`FETCH_WIDTH-1:0]         id_pred_taken;
   pc_t   [`FETCH_WIDTH-1:0]        id_pred_tgt;
   logic [POP_W-1:0]                id_pop_cnt;
   logic                            run_done;
   logic                            report_done;
   int                              err_cnt;
   integer                          seed = 32'hc360ef80;
   int                              cycle_cnt = 0;

   function automatic insn_t mem_word(pc_t p);
      return insn_t'({2'b00, p}) ^ 32'h5a5a_0000;
   endfunction

   // Small code region starting at the reset vector
   function automatic pc_t region_pc();
      return REGION_BASE + pc_t'($unsigned($random(seed)) % 64);
   endfunction

   fetch_frontend fetch_frontend_i (.*);
   fetch_checker chk_i (.*);

   initial clk = 1'b0;
   always #2 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
         $display("Simulation failed");
         $finish;
      end
   end

   // Four-phase memory with a random ack delay of 0 to 3 cycles
   initial
   begin
      int delay;
      imem_ack = 1'b0;
      imem_rdata = '0;
      forever
      begin
         @(negedge clk);
         if (imem_req && !imem_ack)
         begin
            delay = $unsigned($random(seed)) % 4;
            repeat (delay) @(negedge clk);
            for (int i = 0; i < `FETCH_WIDTH; i++)
               imem_rdata[i] = mem_word(imem_addr + pc_t'(i));
            imem_ack = 1'b1;
            while (imem_req)
               @(negedge clk);
            imem_ack = 1'b0;
         end
      end
   end

   initial
   begin
      rst_n = 1'b0;
      flush = 1'b0;
      flush_tgt = '0;
      bpu_wb = 1'b0;
      bpu_wb_taken = 1'b0;
      bpu_wb_pc = '0;
      bpu_wb_tgt = '0;
      id_pop_cnt = '0;
      run_done = 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      for (int c = 0; c < STIM_CYCLES; c++)
      begin
         @(negedge clk);
         flush = ($unsigned($random(seed)) % 60) == 0;
         flush_tgt = region_pc();
         bpu_wb = ($unsigned($random(seed)) % 20) == 0;
         // Mostly taken so the BTB fills up
         bpu_wb_taken = ($unsigned($random(seed)) % 4) != 0;
         bpu_wb_pc = region_pc();
         bpu_wb_tgt = region_pc();
         // Slow decode in every other stretch lets the queue fill up
         if (((c / STALL_PHASE) % 2) == 1 && ($unsigned($random(seed)) % 8) != 0)
            id_pop_cnt = '0;
         else
            id_pop_cnt = POP_W'($unsigned($random(seed)) % ($countones(id_valid) + 1));
      end
      @(negedge clk);
      flush = 1'b0;
      bpu_wb = 1'b0;
      id_pop_cnt = '0;
      run_done = 1'b1;
      wait (report_done);
      if (err_cnt == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

//--- all.f
+incdir+source
source/fetch_pkg.sv
source/pc_gen.sv
source/btb.sv
source/imem_port.sv
source/fetch_queue.sv
source/fetch_frontend.sv
verification/fetch_checker.sv
verification/tb_fetch.sv

//--- run.sh
#!/bin/sh
# Build the fetch front end testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f all.f --top-module tb_fetch -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vtb_fetch > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation run returned status $status"
   exit 1
fi

if grep -q "^Simulation completed successfully$" sim.log; then
   exit 0
fi
echo "Pass message not found in sim.log"
exit 1
